// ==== src/fifo_params.svh ====
`ifndef FIFO_PARAMS_SVH
`define FIFO_PARAMS_SVH

// ----------------------------------------------------------------------
// Memory geometry
// ----------------------------------------------------------------------

`define FIFO_ADDR_W        4                      // 16 entries
`define FIFO_DEPTH         (1 << `FIFO_ADDR_W)    // Always a power of two

// ----------------------------------------------------------------------
// Almost flag thresholds
// ----------------------------------------------------------------------

// Static levels checked against the next fill level
`define FIFO_AFULL_LEVEL   14    // afull at or above this level
`define FIFO_AEMPTY_LEVEL  2     // aempty at or below this level

`endif

// ==== src/fifo_pkg.sv ====
`default_nettype none

`include "fifo_params.svh"

package fifo_pkg;

   // ----------------------------------------------------------------------
   // Shared types
   // ----------------------------------------------------------------------

   // Address into the external memory
   // Low bits of the wrapping write and read counters
   typedef logic [`FIFO_ADDR_W-1:0] addr_t;

   // Fill level from 0 up to FIFO_DEPTH inclusive
   // One bit wider than an address so a full FIFO is distinct from empty
   typedef logic [`FIFO_ADDR_W:0]   level_t;

endpackage

`default_nettype wire

// ==== src/fifo_write_port.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fifo_params.svh"

module fifo_write_port (
   input  logic            pos_clk,
   input  logic            aresetn,
   input  logic            we_i,          // Level write request
   input  logic            full_i,        // From the status block
   output logic            memwe_o,       // Memory write enable
   output fifo_pkg::addr_t memwaddr_o,    // Memory write address
   output logic            wr_accept_o,   // Accepted write back to status
   output logic            wack_o,        // One cycle after an accepted write
   output logic            overflow_o     // One cycle after a refused write
);

   import fifo_pkg::*;

   logic  we_ok;         // Request that passes the full check
   logic  we_refused;    // Request that hits a full FIFO
   logic  wack_q;
   logic  overflow_q;
   addr_t waddr_q;
   addr_t waddr_nxt;

   // ----------------------------------------------------------------------
   // Request gating
   // ----------------------------------------------------------------------

   // Writes stop while full and are not retried
   assign we_ok      = we_i & ~full_i;
   assign we_refused = we_i & full_i;

   // Same strobe to the memory and to the occupancy counter
   assign memwe_o     = we_ok;
   assign wr_accept_o = we_ok;

   // ----------------------------------------------------------------------
   // Write address counter
   // ----------------------------------------------------------------------

   // Wrap from the last entry back to the first
   always_comb begin
      if (waddr_q == addr_t'(`FIFO_DEPTH - 1)) begin
         waddr_nxt = '0;
      end else begin
         waddr_nxt = waddr_q + addr_t'(1);
      end
   end

   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         waddr_q <= '0;
      end else if (we_ok) begin
         waddr_q <= waddr_nxt;    // Advance at the edge ending the write
      end
   end

   assign memwaddr_o = waddr_q;   // Address of the write in this cycle

   // ----------------------------------------------------------------------
   // Handshake and error pulses
   // ----------------------------------------------------------------------

   // Both pulses last one cycle since the request is sampled every edge
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         wack_q     <= 1'b0;
         overflow_q <= 1'b0;
      end else begin
         wack_q     <= we_ok;
         overflow_q <= we_refused;
      end
   end

   assign wack_o     = wack_q;
   assign overflow_o = overflow_q;

endmodule

`default_nettype wire

// ==== src/fifo_read_port.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fifo_params.svh"

module fifo_read_port (
   input  logic            pos_clk,
   input  logic            aresetn,
   input  logic            re_i,          // Level read request
   input  logic            empty_i,       // From the status block
   output logic            memre_o,       // Memory read enable
   output fifo_pkg::addr_t memraddr_o,    // Memory read address
   output logic            rd_accept_o,   // Accepted read back to status
   output logic            dvld_o,        // Read data valid one cycle later
   output logic            underflow_o    // One cycle after a refused read
);

   import fifo_pkg::*;

   logic  re_ok;         // Request that passes the empty check
   logic  re_refused;    // Request that hits an empty FIFO
   logic  dvld_q;
   logic  underflow_q;
   addr_t raddr_q;
   addr_t raddr_nxt;

   // ----------------------------------------------------------------------
   // Request gating
   // ----------------------------------------------------------------------

   // Reads stop while empty and are not retried
   assign re_ok      = re_i & ~empty_i;
   assign re_refused = re_i & empty_i;

   assign memre_o     = re_ok;
   assign rd_accept_o = re_ok;

   // ----------------------------------------------------------------------
   // Read address counter
   // ----------------------------------------------------------------------

   // Last entry rolls over to entry 0
   always_comb begin
      if (raddr_q == addr_t'(`FIFO_DEPTH - 1)) begin
         raddr_nxt = '0;
      end else begin
         raddr_nxt = raddr_q + addr_t'(1);
      end
   end

   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         raddr_q <= '0;
      end else if (re_ok) begin
         raddr_q <= raddr_nxt;
      end
   end

   // Memory samples this address together with memre_o
   assign memraddr_o = raddr_q;

   // ----------------------------------------------------------------------
   // Data valid and underflow
   // ----------------------------------------------------------------------

   // Memory returns data one edge after the read, hence dvld here
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         dvld_q      <= 1'b0;
         underflow_q <= 1'b0;
      end else begin
         dvld_q      <= re_ok;
         underflow_q <= re_refused;    // No dvld for a refused read
      end
   end

   assign dvld_o      = dvld_q;
   assign underflow_o = underflow_q;

endmodule

`default_nettype wire

// ==== src/fifo_status.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fifo_params.svh"

module fifo_status (
   input  logic             pos_clk,
   input  logic             aresetn,
   input  logic             wr_accept_i,   // Write taken this cycle
   input  logic             rd_accept_i,   // Read taken this cycle
   output fifo_pkg::level_t level_o,
   output logic             full_o,
   output logic             afull_o,
   output logic             empty_o,
   output logic             aempty_o
);

   import fifo_pkg::*;

   level_t level_q;
   level_t level_nxt;
   logic   full_q;
   logic   afull_q;
   logic   empty_q;
   logic   aempty_q;

   // ----------------------------------------------------------------------
   // Occupancy counter
   // ----------------------------------------------------------------------

   // A write and a read in the same cycle cancel out
   assign level_nxt = level_q + level_t'(wr_accept_i) - level_t'(rd_accept_i);

   // Flags come from the next level so they line up with level_o
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         level_q  <= '0;
         full_q   <= 1'b0;
         afull_q  <= 1'b0;
         empty_q  <= 1'b1;    // Starts empty
         aempty_q <= 1'b1;
      end else begin
         level_q  <= level_nxt;
         full_q   <= (level_nxt == level_t'(`FIFO_DEPTH));
         afull_q  <= (level_nxt >= level_t'(`FIFO_AFULL_LEVEL));
         empty_q  <= (level_nxt == '0);
         aempty_q <= (level_nxt <= level_t'(`FIFO_AEMPTY_LEVEL));
      end
   end

   assign level_o  = level_q;
   assign full_o   = full_q;
   assign afull_o  = afull_q;
   assign empty_o  = empty_q;
   assign aempty_o = aempty_q;

endmodule

`default_nettype wire

// ==== src/fifo_ctrl_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module fifo_ctrl_top (
   input  logic             pos_clk,
   input  logic             aresetn,
   input  logic             we_i,
   input  logic             re_i,
   output logic             memwe_o,
   output logic             memre_o,
   output fifo_pkg::addr_t  memwaddr_o,
   output fifo_pkg::addr_t  memraddr_o,
   output logic             full_o,
   output logic             afull_o,
   output logic             empty_o,
   output logic             aempty_o,
   output logic             wack_o,
   output logic             dvld_o,
   output logic             overflow_o,
   output logic             underflow_o,
   output fifo_pkg::level_t level_o
);

   logic wr_accept;    // Write port to status
   logic rd_accept;    // Read port to status

   // ----------------------------------------------------------------------
   // Write side gated by full
   // ----------------------------------------------------------------------
   fifo_write_port u_wr (
      .pos_clk     (pos_clk),
      .aresetn     (aresetn),
      .we_i        (we_i),
      .full_i      (full_o),
      .memwe_o     (memwe_o),
      .memwaddr_o  (memwaddr_o),
      .wr_accept_o (wr_accept),
      .wack_o      (wack_o),
      .overflow_o  (overflow_o)
   );

   // Read side gated by empty
   fifo_read_port u_rd (
      .pos_clk     (pos_clk),
      .aresetn     (aresetn),
      .re_i        (re_i),
      .empty_i     (empty_o),
      .memre_o     (memre_o),
      .memraddr_o  (memraddr_o),
      .rd_accept_o (rd_accept),
      .dvld_o      (dvld_o),
      .underflow_o (underflow_o)
   );

   fifo_status u_status (
      .pos_clk     (pos_clk),
      .aresetn     (aresetn),
      .wr_accept_i (wr_accept),
      .rd_accept_i (rd_accept),
      .level_o     (level_o),
      .full_o      (full_o),
      .afull_o     (afull_o),
      .empty_o     (empty_o),
      .aempty_o    (aempty_o)
   );

endmodule

`default_nettype wire

// ==== test/fifo_ctrl_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module fifo_ctrl_properties (
   input logic pos_clk,
   input logic aresetn,
   input logic memwe_i,
   input logic memre_i,
   input logic full_i,
   input logic empty_i,
   input logic wack_i
);

   int unsigned fail_count;    // Failed assertions so far

   initial begin
      fail_count = 0;
   end

   // ----------------------------------------------------------------------
   // Stop rules at the memory interface
   // ----------------------------------------------------------------------

   a_no_write_when_full : assert property (@(posedge pos_clk) disable iff (!aresetn)
      !(memwe_i && full_i))
      else begin
         fail_count++;
         $error("memory write enable high while the FIFO is full");
      end

   a_no_read_when_empty : assert property (@(posedge pos_clk) disable iff (!aresetn)
      !(memre_i && empty_i))
      else begin
         fail_count++;
         $error("memory read enable high while the FIFO is empty");
      end

   // Status flags are mutually exclusive
   a_full_empty_excl : assert property (@(posedge pos_clk) disable iff (!aresetn)
      !(full_i && empty_i))
      else begin
         fail_count++;
         $error("full and empty high together");
      end

   // Acknowledge only for a write that reached the memory
   a_wack_after_write : assert property (@(posedge pos_clk) disable iff (!aresetn)
      wack_i |-> $past(memwe_i))
      else begin
         fail_count++;
         $error("write acknowledge without a write in the previous cycle");
      end

endmodule

bind fifo_ctrl_top fifo_ctrl_properties u_props (
   .pos_clk (pos_clk),
   .aresetn (aresetn),
   .memwe_i (memwe_o),
   .memre_i (memre_o),
   .full_i  (full_o),
   .empty_i (empty_o),
   .wack_i  (wack_o)
);

`default_nettype wire

// ==== test/fifo_ctrl_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module fifo_ctrl_tb;

   import fifo_pkg::*;

   localparam int    clk_period   = 8;
   localparam int    reset_cycles = 3;
   localparam string case_file    = "test/fifo_cases.txt";

   // Label for a case line from its we and re columns
   typedef enum logic [1:0] {
      op_idle  = 2'b00,
      op_read  = 2'b01,
      op_write = 2'b10,
      op_both  = 2'b11
   } op_e;

   typedef struct packed {
      logic   we;
      logic   re;
      logic   memwe;       // Within the cycle
      logic   memre;
      addr_t  waddr;       // After the edge
      addr_t  raddr;
      level_t level;
      logic   full;
      logic   afull;
      logic   empty;
      logic   aempty;
      logic   wack;
      logic   dvld;
      logic   overflow;
      logic   underflow;
   } case_t;

   logic   pos_clk;
   logic   aresetn;
   logic   we;
   logic   re;
   logic   memwe;
   logic   memre;
   addr_t  memwaddr;
   addr_t  memraddr;
   logic   full;
   logic   afull;
   logic   empty;
   logic   aempty;
   logic   wack;
   logic   dvld;
   logic   overflow;
   logic   underflow;
   level_t level;

   case_t  cases[$];
   string  case_names[$];
   string  cur_test;
   logic   cases_loaded;

   fifo_ctrl_top dut (
      .pos_clk     (pos_clk),
      .aresetn     (aresetn),
      .we_i        (we),
      .re_i        (re),
      .memwe_o     (memwe),
      .memre_o     (memre),
      .memwaddr_o  (memwaddr),
      .memraddr_o  (memraddr),
      .full_o      (full),
      .afull_o     (afull),
      .empty_o     (empty),
      .aempty_o    (aempty),
      .wack_o      (wack),
      .dvld_o      (dvld),
      .overflow_o  (overflow),
      .underflow_o (underflow),
      .level_o     (level)
   );

   // ----------------------------------------------------------------------
   // Failure reporting and compare tasks
   // ----------------------------------------------------------------------

   task automatic report_failure(input string why);
      $display("%0s", why);
      $display("SOME TESTS FAILED");
      $fatal(1, "run stopped");
   endtask

   task automatic check_flag(input string sig, input logic exp, input logic act);
      if (act !== exp) begin
         report_failure($sformatf("mismatch %0s %0s: expected %0b, actual %0b",
                                  cur_test, sig, exp, act));
      end
   endtask

   task automatic check_addr(input string sig, input addr_t exp, input addr_t act);
      if (act !== exp) begin
         report_failure($sformatf("mismatch %0s %0s: expected %0d, actual %0d",
                                  cur_test, sig, exp, act));
      end
   endtask

   task automatic check_level(input string sig, input level_t exp, input level_t act);
      if (act !== exp) begin
         report_failure($sformatf("mismatch %0s %0s: expected %0d, actual %0d",
                                  cur_test, sig, exp, act));
      end
   endtask

   function automatic string test_label(input int idx);
      op_e op;
      op = op_e'({cases[idx].we, cases[idx].re});
      return $sformatf("%0s(%0s)", case_names[idx], op.name());
   endfunction

   // ----------------------------------------------------------------------
   // Case file
   // ----------------------------------------------------------------------

   task automatic load_cases();
      int    fd;
      int    n;
      string line;
      string name;
      int    f [0:14];
      case_t c;
      fd = $fopen(case_file, "r");
      if (fd == 0) begin
         report_failure($sformatf("cannot open the case file %0s", case_file));
      end
      while ($fgets(line, fd) != 0) begin
         if (line.len() > 1 && line.getc(0) != "#") begin    // Skip comments and blanks
            n = $sscanf(line, "%s %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d", name,
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                        f[8], f[9], f[10], f[11], f[12], f[13], f[14]);
            if (n != 16) begin
               report_failure($sformatf("a case file line could not be read: %0s", line));
            end
            c.we        = f[0][0];
            c.re        = f[1][0];
            c.memwe     = f[2][0];
            c.memre     = f[3][0];
            c.waddr     = addr_t'(f[4]);
            c.raddr     = addr_t'(f[5]);
            c.level     = level_t'(f[6]);
            c.full      = f[7][0];
            c.afull     = f[8][0];
            c.empty     = f[9][0];
            c.aempty    = f[10][0];
            c.wack      = f[11][0];
            c.dvld      = f[12][0];
            c.overflow  = f[13][0];
            c.underflow = f[14][0];
            cases.push_back(c);
            case_names.push_back(name);
         end
      end
      $fclose(fd);
      if (cases.size() == 0) begin
         report_failure("the case file holds no cases");
      end
   endtask

   // Enables belong to the current cycle
   task automatic check_enables(input int idx);
      cur_test = test_label(idx);
      check_flag("memwe_o", cases[idx].memwe, memwe);
      check_flag("memre_o", cases[idx].memre, memre);
   endtask

   task automatic check_results(input int idx);
      cur_test = test_label(idx);
      check_addr("memwaddr_o", cases[idx].waddr, memwaddr);
      check_addr("memraddr_o", cases[idx].raddr, memraddr);
      check_level("level_o", cases[idx].level, level);
      check_flag("full_o", cases[idx].full, full);
      check_flag("afull_o", cases[idx].afull, afull);
      check_flag("empty_o", cases[idx].empty, empty);
      check_flag("aempty_o", cases[idx].aempty, aempty);
      check_flag("wack_o", cases[idx].wack, wack);
      check_flag("dvld_o", cases[idx].dvld, dvld);
      check_flag("overflow_o", cases[idx].overflow, overflow);
      check_flag("underflow_o", cases[idx].underflow, underflow);
   endtask

   // ----------------------------------------------------------------------
   // Clock, stimulus and watchdog
   // ----------------------------------------------------------------------

   initial begin
      pos_clk = 1'b0;
      forever begin
         #(clk_period / 2) pos_clk = ~pos_clk;
      end
   end

   initial begin
      aresetn      = 1'b0;
      we           = 1'b0;
      re           = 1'b0;
      cases_loaded = 1'b0;
      load_cases();
      cases_loaded = 1'b1;
      repeat (reset_cycles) @(posedge pos_clk);
      aresetn <= 1'b1;
      // One extra idle cycle at the end to see the last results
      for (int i = 0; i <= cases.size(); i++) begin
         @(posedge pos_clk);
         if (i < cases.size()) begin
            we <= cases[i].we;
            re <= cases[i].re;
         end else begin
            we <= 1'b0;
            re <= 1'b0;
         end
         @(negedge pos_clk);    // Outputs settled mid cycle
         if (i > 0) begin
            check_results(i - 1);
         end
         if (i < cases.size()) begin
            check_enables(i);
         end
      end
      $display("ALL TESTS PASSED");
      $finish;
   end

   // Bound checker failures end the run too
   initial begin
      wait (dut.u_props.fail_count != 0);
      report_failure("an assertion bound to the DUT failed");
   end

   initial begin
      int watchdog_ns;
      wait (cases_loaded === 1'b1);
      watchdog_ns = cases.size() * clk_period * 2 + reset_cycles * clk_period;
      #(watchdog_ns);
      report_failure("the run timed out before the last case was checked");
   end

endmodule

`default_nettype wire

// ==== test/fifo_cases.txt ====
# name we re memwe memre waddr raddr level full afull empty aempty wack dvld ovf udf
# memwe and memre are for the cycle itself, the other columns hold after the edge ending it
rst_idle  0 0  0 0   0  0   0  0 0 1 1  0 0 0 0
wr_01     1 0  1 0   1  0   1  0 0 0 1  1 0 0 0
wr_02     1 0  1 0   2  0   2  0 0 0 1  1 0 0 0
wr_03     1 0  1 0   3  0   3  0 0 0 0  1 0 0 0
wr_04     1 0  1 0   4  0   4  0 0 0 0  1 0 0 0
wr_05     1 0  1 0   5  0   5  0 0 0 0  1 0 0 0
wr_06     1 0  1 0   6  0   6  0 0 0 0  1 0 0 0
wr_07     1 0  1 0   7  0   7  0 0 0 0  1 0 0 0
wr_08     1 0  1 0   8  0   8  0 0 0 0  1 0 0 0
wr_09     1 0  1 0   9  0   9  0 0 0 0  1 0 0 0
wr_10     1 0  1 0  10  0  10  0 0 0 0  1 0 0 0
wr_11     1 0  1 0  11  0  11  0 0 0 0  1 0 0 0
wr_12     1 0  1 0  12  0  12  0 0 0 0  1 0 0 0
wr_13     1 0  1 0  13  0  13  0 0 0 0  1 0 0 0
wr_14     1 0  1 0  14  0  14  0 1 0 0  1 0 0 0
wr_15     1 0  1 0  15  0  15  0 1 0 0  1 0 0 0
wr_16     1 0  1 0   0  0  16  1 1 0 0  1 0 0 0
wr_full   1 0  0 0   0  0  16  1 1 0 0  0 0 1 0
rd_01     0 1  0 1   0  1  15  0 1 0 0  0 1 0 0
rd_02     0 1  0 1   0  2  14  0 1 0 0  0 1 0 0
rd_03     0 1  0 1   0  3  13  0 0 0 0  0 1 0 0
rd_04     0 1  0 1   0  4  12  0 0 0 0  0 1 0 0
rd_05     0 1  0 1   0  5  11  0 0 0 0  0 1 0 0
rd_06     0 1  0 1   0  6  10  0 0 0 0  0 1 0 0
rd_07     0 1  0 1   0  7   9  0 0 0 0  0 1 0 0
rd_08     0 1  0 1   0  8   8  0 0 0 0  0 1 0 0
both_01   1 1  1 1   1  9   8  0 0 0 0  1 1 0 0
both_02   1 1  1 1   2 10   8  0 0 0 0  1 1 0 0
both_03   1 1  1 1   3 11   8  0 0 0 0  1 1 0 0
both_04   1 1  1 1   4 12   8  0 0 0 0  1 1 0 0
both_05   1 1  1 1   5 13   8  0 0 0 0  1 1 0 0
both_06   1 1  1 1   6 14   8  0 0 0 0  1 1 0 0
both_07   1 1  1 1   7 15   8  0 0 0 0  1 1 0 0
both_08   1 1  1 1   8  0   8  0 0 0 0  1 1 0 0
drn_01    0 1  0 1   8  1   7  0 0 0 0  0 1 0 0
drn_02    0 1  0 1   8  2   6  0 0 0 0  0 1 0 0
drn_03    0 1  0 1   8  3   5  0 0 0 0  0 1 0 0
drn_04    0 1  0 1   8  4   4  0 0 0 0  0 1 0 0
drn_05    0 1  0 1   8  5   3  0 0 0 0  0 1 0 0
drn_06    0 1  0 1   8  6   2  0 0 0 1  0 1 0 0
drn_07    0 1  0 1   8  7   1  0 0 0 1  0 1 0 0
drn_08    0 1  0 1   8  8   0  0 0 1 1  0 1 0 0
rd_empty  0 1  0 0   8  8   0  0 0 1 1  0 0 0 1

// ==== files.f ====
+incdir+src
src/fifo_pkg.sv
src/fifo_write_port.sv
src/fifo_read_port.sv
src/fifo_status.sv
src/fifo_ctrl_top.sv
test/fifo_ctrl_properties.sv
test/fifo_ctrl_tb.sv

// ==== Makefile ====
# Verilator build and run for the FIFO controller testbench

VERILATOR ?= verilator
TOP       ?= fifo_ctrl_tb
FLAGS     ?= --binary --timing --assert --timescale 1ns/1ps
OBJ_DIR   ?= obj_dir
FILELIST  := files.f
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(wildcard src/*.sv src/*.svh test/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Output goes to the terminal, the search decides the exit status
run: compile
	$(SIM) | tee /dev/stderr | grep -q "ALL TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)
